//--- pad_subsys_top.f
+incdir+.
pad_ctrl_pkg.sv
pad_reg_bus_if.sv
pad_control_reg_top.sv
pad_control.sv
pad_io_mux.sv
pad_subsys_top.sv
pad_subsys_asserts.sv
tb_pad_subsys.sv

//--- tb_pad_subsys.sv
// -------------------------------------------------
// Testbench for pad_subsys_top with bus tasks, a
// register model, random pad stimulus and the report.
// -------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "pad_ctrl_settings.svh"

module tb_pad_subsys;

  localparam int CLK_PERIOD = 40;
  localparam int RSP_TIMEOUT = 8;

  logic                      clk;
  logic                      rst_n;
  logic                      reg_valid;
  logic                      reg_write;
  logic [7:0]                reg_addr;
  logic [31:0]               reg_wdata;
  logic                      reg_rsp_valid;
  logic [31:0]               reg_rdata;
  logic                      reg_error;
  logic [`PAD_NUM-1:0]       core_out;
  logic [`PAD_NUM-1:0]       core_oe;
  logic [`PAD_NUM-1:0]       gpio_out;
  logic [`PAD_NUM-1:0]       gpio_oe;
  logic [`PAD_NUM-1:0]       pad_in;
  logic [`PAD_NUM-1:0]       pad_out;
  logic [`PAD_NUM-1:0]       pad_oe;
  logic [`PAD_NUM-1:0]       pad_pu;
  logic [`PAD_NUM-1:0]       pad_pd;
  logic [`PAD_NUM-1:0]       core_in;
  logic [`PAD_NUM-1:0][4:0]  pad_drv;

  logic [7:0]  attr_model [`PAD_NUM];
  logic [3:0]  mux_model [`PAD_NUM];  // Pads without a mux register stay 0.
  logic [7:0]  bad_addr [10] = '{8'h20, 8'h3c, 8'h60, 8'hfc, 8'h01,
                                 8'h42, 8'h07, 8'h54, 8'h58, 8'h5c};
  integer      seed = 32'haf14c1ef;
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned timeouts = 0;
  int unsigned assert_fails;

  pad_subsys_top pad_subsys_top_inst (
    .clk_i (clk), .rst_n_i (rst_n),
    .reg_valid_i (reg_valid), .reg_write_i (reg_write),
    .reg_addr_i (reg_addr), .reg_wdata_i (reg_wdata),
    .reg_rsp_valid_o (reg_rsp_valid), .reg_rdata_o (reg_rdata),
    .reg_error_o (reg_error),
    .core_out_i (core_out), .core_oe_i (core_oe),
    .gpio_out_i (gpio_out), .gpio_oe_i (gpio_oe), .pad_in_i (pad_in),
    .pad_out_o (pad_out), .pad_oe_o (pad_oe), .pad_pu_o (pad_pu),
    .pad_pd_o (pad_pd), .core_in_o (core_in), .pad_drv_o (pad_drv)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [7:0] attr_addr(input int idx);
    return 8'(`PAD_ATTR_BASE + 4 * idx);
  endfunction

  function automatic logic [7:0] mux_addr(input int idx);
    return 8'(`PAD_MUX_BASE + 4 * idx);
  endfunction

  // Misaligned, unmapped or above the muxable pads.
  function automatic logic addr_error(input logic [7:0] addr);
    if (addr[1:0] != 2'b00) return 1'b1;
    if (addr >= `PAD_ATTR_BASE && addr < `PAD_ATTR_BASE + 4 * `PAD_NUM) return 1'b0;
    if (addr >= `PAD_MUX_BASE && addr < `PAD_MUX_BASE + 4 * `PAD_MUX_NUM) return 1'b0;
    return 1'b1;
  endfunction

  function automatic logic [31:0] model_read(input logic [7:0] addr);
    if (addr_error(addr)) return 32'h0;
    if (addr < `PAD_MUX_BASE) return {24'h0, attr_model[(addr - `PAD_ATTR_BASE) >> 2]};
    return {28'h0, mux_model[(addr - `PAD_MUX_BASE) >> 2]};
  endfunction

  task automatic model_write(input logic [7:0] addr, input logic [31:0] data);
    if (!addr_error(addr)) begin
      if (addr < `PAD_MUX_BASE) attr_model[(addr - `PAD_ATTR_BASE) >> 2] = data[7:0];
      else mux_model[(addr - `PAD_MUX_BASE) >> 2] = data[3:0];
    end
  endtask

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic drive_request(input logic write, input logic [7:0] addr,
                               input logic [31:0] wdata);
    reg_valid = 1'b1;
    reg_write = write;
    reg_addr = addr;
    reg_wdata = wdata;
  endtask

  task automatic check_response(input logic write, input logic [7:0] addr,
                                input logic [31:0] exp_data, input logic exp_err);
    int waited;
    waited = 0;
    while (!reg_rsp_valid && waited < RSP_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!reg_rsp_valid) begin
      timeouts++;
      $display("Timeout: no bus response for address %h at %0t", addr, $time);
    end else begin
      check_value("response latency", waited, 0);
      check_value("reg_error_o", reg_error, exp_err);
      if (!write) begin
        check_value("reg_rdata_o", reg_rdata, exp_data);
      end
    end
  endtask

  task automatic transact(input logic write, input logic [7:0] addr,
                          input logic [31:0] wdata);
    logic [31:0] exp_data;
    exp_data = model_read(addr);
    @(negedge clk);
    drive_request(write, addr, wdata);
    @(negedge clk);
    reg_valid = 1'b0;
    if (write) model_write(addr, wdata);
    check_response(write, addr, exp_data, addr_error(addr));
  endtask

  // Second request goes out while the first response is on the bus.
  task automatic back_to_back(input logic w0, input logic [7:0] a0, input logic [31:0] d0,
                              input logic w1, input logic [7:0] a1, input logic [31:0] d1);
    logic [31:0] exp_data;
    exp_data = model_read(a0);
    @(negedge clk);
    drive_request(w0, a0, d0);
    @(negedge clk);
    drive_request(w1, a1, d1);
    if (w0) model_write(a0, d0);
    check_response(w0, a0, exp_data, addr_error(a0));
    exp_data = model_read(a1);
    @(negedge clk);
    reg_valid = 1'b0;
    if (w1) model_write(a1, d1);
    check_response(w1, a1, exp_data, addr_error(a1));
  endtask

  task automatic check_pads();
    logic [`PAD_NUM-1:0]      exp_out;
    logic [`PAD_NUM-1:0]      exp_oe;
    logic [`PAD_NUM-1:0]      exp_pu;
    logic [`PAD_NUM-1:0]      exp_pd;
    logic [`PAD_NUM-1:0]      exp_in;
    logic [`PAD_NUM-1:0][4:0] exp_drv;
    logic [7:0]               attr;
    for (int i = 0; i < `PAD_NUM; i++) begin
      attr = attr_model[i];
      exp_out[i] = (mux_model[i] == 0) ? core_out[i] : (mux_model[i] == 1) & gpio_out[i];
      exp_oe[i] = (mux_model[i] == 0) ? core_oe[i] : (mux_model[i] == 1) & gpio_oe[i];
      exp_in[i] = pad_in[i] & attr[0];
      exp_pu[i] = (attr[2:1] == 2'b01);
      exp_pd[i] = (attr[2:1] == 2'b10);
      exp_drv[i] = attr[7:3];
    end
    check_value("pad_out_o", pad_out, exp_out);
    check_value("pad_oe_o", pad_oe, exp_oe);
    check_value("pad_pu_o", pad_pu, exp_pu);
    check_value("pad_pd_o", pad_pd, exp_pd);
    check_value("core_in_o", core_in, exp_in);
    check_value("pad_drv_o", pad_drv, exp_drv);
  endtask

  task automatic pad_round();
    @(negedge clk);
    core_out = $random(seed);
    core_oe = $random(seed);
    gpio_out = $random(seed);
    gpio_oe = $random(seed);
    pad_in = $random(seed);
    @(negedge clk);
    check_pads();
  endtask

  initial begin
    rst_n = 1'b0;
    // A write request held through reset gets no response and no effect.
    reg_valid = 1'b1;
    reg_write = 1'b1;
    reg_addr = '0;
    reg_wdata = 32'hff;
    core_out = '0;
    core_oe = '0;
    gpio_out = '0;
    gpio_oe = '0;
    pad_in = '0;
    for (int i = 0; i < `PAD_NUM; i++) begin
      attr_model[i] = `PAD_ATTR_RESET;
      mux_model[i] = 4'h0;
    end
    repeat (10) @(negedge clk);
    reg_valid = 1'b0;
    rst_n = 1'b1;

    for (int i = 0; i < `PAD_NUM; i++) transact(1'b0, attr_addr(i), 0);
    for (int i = 0; i < `PAD_MUX_NUM; i++) transact(1'b0, mux_addr(i), 0);
    repeat (4) pad_round();

    for (int i = 0; i < `PAD_NUM; i++) begin
      transact(1'b1, attr_addr(i), $random(seed));
      transact(1'b0, attr_addr(i), 0);
      pad_round();
    end

    // Pull-up only, pull-down only, then both.
    for (int i = 0; i < `PAD_NUM; i++) begin
      transact(1'b1, attr_addr(i), 32'h0b);
      pad_round();
      transact(1'b1, attr_addr(i), 32'h0d);
      pad_round();
      transact(1'b1, attr_addr(i), 32'h0f);
      pad_round();
    end

    for (int i = 0; i < `PAD_MUX_NUM; i++) begin
      for (int v = 1; v < 16; v++) begin
        transact(1'b1, mux_addr(i), v);
        transact(1'b0, mux_addr(i), 0);
        pad_round();
      end
      transact(1'b1, mux_addr(i), 0);
    end

    foreach (bad_addr[k]) begin
      transact(1'b1, bad_addr[k], $random(seed));
      transact(1'b0, bad_addr[k], 0);
    end
    for (int i = 0; i < `PAD_NUM; i++) transact(1'b0, attr_addr(i), 0);
    for (int i = 0; i < `PAD_MUX_NUM; i++) transact(1'b0, mux_addr(i), 0);

    back_to_back(1'b1, attr_addr(2), 32'hc5, 1'b0, attr_addr(2), 0);
    back_to_back(1'b0, attr_addr(2), 0, 1'b0, attr_addr(3), 0);
    back_to_back(1'b1, mux_addr(1), 32'h1, 1'b0, 8'h58, 0);
    pad_round();

    repeat (2) @(negedge clk);
    assert_fails = pad_subsys_top_inst.pad_subsys_asserts_inst.fail_count;
    $display("Checks: %0d, errors: %0d, timeouts: %0d, assertion failures: %0d",
             checks, errors, timeouts, assert_fails);
    if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- pad_subsys_asserts.sv
// -------------------------------------------------
// Concurrent assertions for the pad subsystem top
// level, bound to pad_subsys_top.
// -------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "pad_ctrl_settings.svh"

module pad_subsys_asserts (
  input logic                                   clk_i,
  input logic                                   rst_n_i,
  input logic                                   reg_valid_i,
  input logic                                   rsp_valid_i,
  input logic [`PAD_NUM-1:0]                    pad_pu_i,
  input logic [`PAD_NUM-1:0]                    pad_pd_i,
  input logic [`PAD_NUM-1:0]                    pad_oe_i,
  input logic [`PAD_NUM-1:0]                    pad_out_i,
  input pad_ctrl_pkg::pad_mux_t [`PAD_NUM-1:0]  pad_muxes_i
);

  int unsigned fail_count = 0;  // Failed assertion count.

  rsp_after_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reg_valid_i |=> rsp_valid_i)
  else begin
    fail_count++;
    $error("No response one cycle after a request.");
  end

  // No response without a request.
  no_spurious_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !reg_valid_i |=> !rsp_valid_i)
  else begin
    fail_count++;
    $error("Response seen without a request one cycle earlier.");
  end

  pulls_exclusive: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (pad_pu_i & pad_pd_i) == '0)
  else begin
    fail_count++;
    $error("Pull-up and pull-down both on for one pad.");
  end

  for (genvar i = 0; i < `PAD_MUX_NUM; i++) begin : g_mux
    reserved_mux_off: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (pad_muxes_i[i] > pad_ctrl_pkg::MUX_GPIO) |-> (!pad_oe_i[i] && !pad_out_i[i]))
    else begin
      fail_count++;
      $error("Pad %0d drives its output with a reserved mux value.", i);
    end
  end

  rsp_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !rsp_valid_i)
  else begin
    fail_count++;
    $error("Response valid high while in reset.");
  end

endmodule

bind pad_subsys_top pad_subsys_asserts pad_subsys_asserts_inst (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .reg_valid_i (reg_valid_i),
  .rsp_valid_i (reg_rsp_valid_o),
  .pad_pu_i    (pad_pu_o),
  .pad_pd_i    (pad_pd_o),
  .pad_oe_i    (pad_oe_o),
  .pad_out_i   (pad_out_o),
  .pad_muxes_i (pad_muxes)
);

`default_nettype wire

//--- pad_subsys_top.sv
// -------------------------------------------------
// Pad subsystem top level: register bus, pad control
// and pad multiplexer.
// -------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "pad_ctrl_settings.svh"

module pad_subsys_top (
  input  logic                                  clk_i,
  input  logic                                  rst_n_i,

  // Register bus.
  input  logic                                  reg_valid_i,
  input  logic                                  reg_write_i,
  input  pad_ctrl_pkg::reg_addr_t               reg_addr_i,
  input  pad_ctrl_pkg::reg_data_t               reg_wdata_i,
  output logic                                  reg_rsp_valid_o,
  output pad_ctrl_pkg::reg_data_t               reg_rdata_o,
  output logic                                  reg_error_o,

  // Core, GPIO and pad side.
  input  logic [`PAD_NUM-1:0]                   core_out_i,
  input  logic [`PAD_NUM-1:0]                   core_oe_i,
  input  logic [`PAD_NUM-1:0]                   gpio_out_i,
  input  logic [`PAD_NUM-1:0]                   gpio_oe_i,
  input  logic [`PAD_NUM-1:0]                   pad_in_i,
  output logic [`PAD_NUM-1:0]                   pad_out_o,
  output logic [`PAD_NUM-1:0]                   pad_oe_o,
  output logic [`PAD_NUM-1:0]                   pad_pu_o,
  output logic [`PAD_NUM-1:0]                   pad_pd_o,
  output logic [`PAD_NUM-1:0]                   core_in_o,
  output pad_ctrl_pkg::pad_drv_t [`PAD_NUM-1:0] pad_drv_o
);

  pad_ctrl_pkg::pad_attr_t [`PAD_NUM-1:0] pad_attributes;
  pad_ctrl_pkg::pad_mux_t  [`PAD_NUM-1:0] pad_muxes;

  pad_reg_bus_if reg_bus (
    .clk_i (clk_i)
  );

  // Host side of the bus.
  assign reg_bus.valid = reg_valid_i;
  assign reg_bus.write = reg_write_i;
  assign reg_bus.addr = reg_addr_i;
  assign reg_bus.wdata = reg_wdata_i;
  assign reg_rsp_valid_o = reg_bus.rsp_valid;
  assign reg_rdata_o = reg_bus.rdata;
  assign reg_error_o = reg_bus.error;

  pad_control pad_control_inst (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .bus              (reg_bus.device),
    .pad_attributes_o (pad_attributes),
    .pad_muxes_o      (pad_muxes)
  );

  pad_io_mux pad_io_mux_inst (
    .pad_attributes_i (pad_attributes),
    .pad_muxes_i      (pad_muxes),
    .core_out_i       (core_out_i),
    .core_oe_i        (core_oe_i),
    .gpio_out_i       (gpio_out_i),
    .gpio_oe_i        (gpio_oe_i),
    .pad_in_i         (pad_in_i),
    .pad_out_o        (pad_out_o),
    .pad_oe_o         (pad_oe_o),
    .pad_pu_o         (pad_pu_o),
    .pad_pd_o         (pad_pd_o),
    .core_in_o        (core_in_o),
    .pad_drv_o        (pad_drv_o)
  );

endmodule

`default_nettype wire

//--- pad_io_mux.sv
// -------------------------------------------------
// Pad multiplexer: output source selection, input
// gating, pull resolution and drive strength.
// -------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "pad_ctrl_settings.svh"

module pad_io_mux (
  input  pad_ctrl_pkg::pad_attr_t [`PAD_NUM-1:0] pad_attributes_i,
  input  pad_ctrl_pkg::pad_mux_t  [`PAD_NUM-1:0] pad_muxes_i,
  input  logic [`PAD_NUM-1:0]                    core_out_i,
  input  logic [`PAD_NUM-1:0]                    core_oe_i,
  input  logic [`PAD_NUM-1:0]                    gpio_out_i,
  input  logic [`PAD_NUM-1:0]                    gpio_oe_i,
  input  logic [`PAD_NUM-1:0]                    pad_in_i,
  output logic [`PAD_NUM-1:0]                    pad_out_o,
  output logic [`PAD_NUM-1:0]                    pad_oe_o,
  output logic [`PAD_NUM-1:0]                    pad_pu_o,
  output logic [`PAD_NUM-1:0]                    pad_pd_o,
  output logic [`PAD_NUM-1:0]                    core_in_o,
  output pad_ctrl_pkg::pad_drv_t [`PAD_NUM-1:0]  pad_drv_o
);

  for (genvar i = 0; i < `PAD_NUM; i++) begin : g_pad
    pad_ctrl_pkg::pad_attr_t attr;
    logic                    sel_core;
    logic                    sel_gpio;
    logic                    pu_req;
    logic                    pd_req;

    assign attr = pad_attributes_i[i];

    if (i < `PAD_MUX_NUM) begin : g_muxed
      assign sel_core = (pad_muxes_i[i] == pad_ctrl_pkg::MUX_PRIMARY);
      assign sel_gpio = (pad_muxes_i[i] == pad_ctrl_pkg::MUX_GPIO);
    end else begin : g_fixed
      assign sel_core = 1'b1;  // Always the core function.
      assign sel_gpio = 1'b0;
    end

    // Reserved selects leave both terms low.
    assign pad_out_o[i] = (sel_core & core_out_i[i]) | (sel_gpio & gpio_out_i[i]);
    assign pad_oe_o[i] = (sel_core & core_oe_i[i]) | (sel_gpio & gpio_oe_i[i]);

    assign core_in_o[i] = pad_in_i[i] & attr[pad_ctrl_pkg::ATTR_IE_BIT];

    // Conflicting pulls cancel.
    assign pu_req = attr[pad_ctrl_pkg::ATTR_PU_BIT];
    assign pd_req = attr[pad_ctrl_pkg::ATTR_PD_BIT];
    assign pad_pu_o[i] = pu_req & ~pd_req;
    assign pad_pd_o[i] = pd_req & ~pu_req;

    assign pad_drv_o[i] = attr[pad_ctrl_pkg::ATTR_DRV_LSB +: $bits(pad_ctrl_pkg::pad_drv_t)];
  end

endmodule

`default_nettype wire

//--- pad_control.sv
// -------------------------------------------------
// Pad control block: register file plus per-pad
// attribute and mux vectors.
// -------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "pad_ctrl_settings.svh"

module pad_control (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  pad_reg_bus_if.device                          bus,
  output pad_ctrl_pkg::pad_attr_t [`PAD_NUM-1:0] pad_attributes_o,
  output pad_ctrl_pkg::pad_mux_t  [`PAD_NUM-1:0] pad_muxes_o
);

  pad_ctrl_pkg::pad_attr_t [`PAD_NUM-1:0]     pad_attr;
  pad_ctrl_pkg::pad_mux_t  [`PAD_MUX_NUM-1:0] pad_mux;

  pad_control_reg_top pad_control_reg_top_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .bus        (bus),
    .pad_attr_o (pad_attr),
    .pad_mux_o  (pad_mux)
  );

  assign pad_attributes_o[pad_ctrl_pkg::UART_RX] = pad_attr[pad_ctrl_pkg::UART_RX];
  assign pad_attributes_o[pad_ctrl_pkg::UART_TX] = pad_attr[pad_ctrl_pkg::UART_TX];
  assign pad_attributes_o[pad_ctrl_pkg::EXIT_VALID] = pad_attr[pad_ctrl_pkg::EXIT_VALID];
  assign pad_attributes_o[pad_ctrl_pkg::I2C_SCL] = pad_attr[pad_ctrl_pkg::I2C_SCL];
  assign pad_attributes_o[pad_ctrl_pkg::I2C_SDA] = pad_attr[pad_ctrl_pkg::I2C_SDA];
  assign pad_attributes_o[pad_ctrl_pkg::GPIO_0] = pad_attr[pad_ctrl_pkg::GPIO_0];
  assign pad_attributes_o[pad_ctrl_pkg::GPIO_1] = pad_attr[pad_ctrl_pkg::GPIO_1];
  assign pad_attributes_o[pad_ctrl_pkg::SPI_SCK] = pad_attr[pad_ctrl_pkg::SPI_SCK];

  // One mux field per pad.
  for (genvar i = 0; i < `PAD_NUM; i++) begin : g_mux
    if (i < `PAD_MUX_NUM) begin : g_reg
      assign pad_muxes_o[i] = pad_mux[i];
    end else begin : g_fixed
      assign pad_muxes_o[i] = pad_ctrl_pkg::MUX_PRIMARY;  // No register.
    end
  end

endmodule

`default_nettype wire

//--- pad_control_reg_top.sv
// -------------------------------------------------
// Pad control register file with address decode, the
// attribute and mux registers and the read response.
// -------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

`include "pad_ctrl_settings.svh"

module pad_control_reg_top (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,
  pad_reg_bus_if.device                              bus,
  output pad_ctrl_pkg::pad_attr_t [`PAD_NUM-1:0]     pad_attr_o,
  output pad_ctrl_pkg::pad_mux_t  [`PAD_MUX_NUM-1:0] pad_mux_o
);

  localparam int unsigned IDX_W = $clog2(`PAD_NUM);
  localparam int unsigned OFS_W = $clog2(`PAD_REG_STRIDE);
  localparam int unsigned SPAN = `PAD_NUM * `PAD_REG_STRIDE;

  pad_ctrl_pkg::pad_attr_t [`PAD_NUM-1:0]     attr_q;
  pad_ctrl_pkg::pad_mux_t  [`PAD_MUX_NUM-1:0] mux_q;

  pad_ctrl_pkg::reg_addr_t attr_ofs;
  pad_ctrl_pkg::reg_addr_t mux_ofs;
  logic [IDX_W-1:0]        attr_idx;
  logic [IDX_W-1:0]        mux_idx;
  logic                    aligned;
  logic                    attr_hit;
  logic                    mux_hit;
  logic                    req_ok;
  logic                    wr_en;
  pad_ctrl_pkg::reg_data_t rd_data;

  logic                    rsp_valid_q;
  logic                    error_q;
  pad_ctrl_pkg::reg_data_t rdata_q;

  // Offsets wrap to large values below each base.
  assign attr_ofs = bus.addr - pad_ctrl_pkg::reg_addr_t'(`PAD_ATTR_BASE);
  assign mux_ofs = bus.addr - pad_ctrl_pkg::reg_addr_t'(`PAD_MUX_BASE);
  assign attr_idx = attr_ofs[OFS_W +: IDX_W];
  assign mux_idx = mux_ofs[OFS_W +: IDX_W];

  assign aligned = (bus.addr[OFS_W-1:0] == '0);
  assign attr_hit = aligned && (attr_ofs < pad_ctrl_pkg::reg_addr_t'(SPAN));
  assign mux_hit = aligned && (mux_ofs < pad_ctrl_pkg::reg_addr_t'(SPAN))
                   && (mux_idx < `PAD_MUX_NUM);  // No mux register above.
  assign req_ok = attr_hit || mux_hit;
  assign wr_en = bus.valid && bus.write && req_ok;

  always_comb begin
    rd_data = '0;  // Errors read as zero.
    if (attr_hit) begin
      rd_data = pad_ctrl_pkg::reg_data_t'(attr_q[attr_idx]);
    end else if (mux_hit) begin
      rd_data = pad_ctrl_pkg::reg_data_t'(mux_q[mux_idx]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      attr_q <= {`PAD_NUM{pad_ctrl_pkg::pad_attr_t'(`PAD_ATTR_RESET)}};
      mux_q <= {`PAD_MUX_NUM{pad_ctrl_pkg::pad_mux_t'(`PAD_MUX_RESET)}};
    end else if (wr_en) begin
      if (attr_hit) begin
        attr_q[attr_idx] <= bus.wdata[$bits(pad_ctrl_pkg::pad_attr_t)-1:0];
      end else begin
        mux_q[mux_idx] <= bus.wdata[$bits(pad_ctrl_pkg::pad_mux_t)-1:0];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      rsp_valid_q <= bus.valid;
      if (bus.valid) begin
        error_q <= !req_ok;
      end
    end
  end

  // Write responses carry zero read data.
  always_ff @(posedge clk_i) begin
    if (bus.valid) begin
      rdata_q <= bus.write ? '0 : rd_data;
    end
  end

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rdata = rdata_q;
  assign bus.error = error_q;

  assign pad_attr_o = attr_q;
  assign pad_mux_o = mux_q;

endmodule

`default_nettype wire

//--- pad_reg_bus_if.sv
// -------------------------------------------------
// Register bus between the top level and the pad
// control register file.
// -------------------------------------------------
`timescale 1ns/1ns
`default_nettype none

interface pad_reg_bus_if (
  input logic clk_i
);

  // One-cycle request strobe.
  logic                    valid;
  logic                    write;
  pad_ctrl_pkg::reg_addr_t addr;
  pad_ctrl_pkg::reg_data_t wdata;

  // Response exactly one cycle after the request.
  logic                    rsp_valid;
  pad_ctrl_pkg::reg_data_t rdata;
  logic                    error;

  modport host (
    input  clk_i,
    output valid, write, addr, wdata,
    input  rsp_valid, rdata, error
  );

  modport device (
    input  clk_i,
    input  valid, write, addr, wdata,
    output rsp_valid, rdata, error
  );

endinterface

`default_nettype wire

//--- pad_ctrl_pkg.sv
// -------------------------------------------------
// Pad control types: attribute and mux words, bus
// fields, pad names and attribute bit positions.
// -------------------------------------------------
`default_nettype none

package pad_ctrl_pkg;

  typedef logic [7:0] pad_attr_t;
  typedef logic [3:0] pad_mux_t;
  typedef logic [4:0] pad_drv_t;  // Drive strength field.

  typedef logic [7:0] reg_addr_t;  // Byte address.
  typedef logic [31:0] reg_data_t;

  typedef enum logic [2:0] {
    UART_RX    = 3'd0,
    UART_TX    = 3'd1,
    EXIT_VALID = 3'd2,
    I2C_SCL    = 3'd3,
    I2C_SDA    = 3'd4,
    GPIO_0     = 3'd5,
    GPIO_1     = 3'd6,
    SPI_SCK    = 3'd7
  } pad_idx_e;

  // Attribute word layout.
  localparam int unsigned ATTR_IE_BIT = 0;
  localparam int unsigned ATTR_PU_BIT = 1;
  localparam int unsigned ATTR_PD_BIT = 2;
  localparam int unsigned ATTR_DRV_LSB = 3;

  localparam pad_mux_t MUX_PRIMARY = 4'd0;
  localparam pad_mux_t MUX_GPIO = 4'd1;  // Anything above is reserved.

endpackage

`default_nettype wire

//--- pad_ctrl_settings.svh
// -------------------------------------------------
// Pad ring size, register map offsets and register
// reset values for the pad control subsystem.
// -------------------------------------------------
`ifndef PAD_CTRL_SETTINGS_SVH
`define PAD_CTRL_SETTINGS_SVH

`define PAD_NUM 8
`define PAD_MUX_NUM 5  // Muxable pads sit at the lowest indices.

`define PAD_REG_STRIDE 4  // Word-spaced registers.
`define PAD_ATTR_BASE 8'h00
`define PAD_MUX_BASE 8'h40

`define PAD_ATTR_RESET 8'h01  // Input enabled, no pulls.
`define PAD_MUX_RESET 4'h0  // Primary core function.

`endif
